//--- logic/huffAlphabetPkg.sv
package huffAlphabetPkg;

    //============================================================
    // Symbol alphabet of the code tree
    //============================================================

    localparam int SymbolCount = 32;

    typedef logic [$clog2(SymbolCount)-1:0] symbolIndex_t;  // Leaf number in tree order
    typedef logic [4:0]                     decodedValue_t;

    localparam symbolIndex_t IdleSymbol = 5'd31;  // Leaf A, decodes to 0

    // Leaf index to decoded value
    localparam decodedValue_t DecodeTable [SymbolCount] = '{
        5'd18,  // S
        5'd10,  // K
        5'd17,  // R
        5'd9,   // J
        5'd19,  // T
        5'd16,  // Q
        5'd8,   // I
        5'd20,  // U
        5'd11,  // L
        5'd21,  // V
        5'd7,   // H
        5'd15,  // P
        5'd12,  // M
        5'd22,  // W
        5'd6,   // G
        5'd23,  // X
        5'd14,  // O
        5'd5,   // F
        5'd13,  // N
        5'd24,  // Y
        5'd4,   // E
        5'd25,  // Z
        5'd26,  // a
        5'd3,   // D
        5'd2,   // C
        5'd1,   // B
        5'd29,  // d
        5'd30,  // e
        5'd28,  // c
        5'd27,  // b
        5'd31,  // f
        5'd0    // A
    };

endpackage

//--- logic/huffStreamPkg.sv
package huffStreamPkg;

    //============================================================
    // Encoded stream and bit window
    //============================================================

    localparam int WordWidth     = 10;  // Input word and longest code
    localparam int WindowWidth   = 20;
    localparam int MinCodeLength = 3;

    typedef logic [WordWidth-1:0]               codeWord_t;    // Oldest bit in MSB
    typedef logic [3:0]                         codeLength_t;
    typedef logic [$clog2(WindowWidth+1)-1:0]   fillCount_t;   // 0 to 20 valid bits
    typedef logic [WindowWidth-1:0]             window_t;      // Left aligned

    // Matcher to window and output stage
    typedef struct packed {
        logic                          valid;
        huffAlphabetPkg::symbolIndex_t symbol;
        codeLength_t                   length;
    } matchResult_t;

endpackage

//--- logic/bitWindow.sv
`timescale 1ns/1ps

module bitWindow (
    input  logic                        clk,
    input  logic                        rst,
    input  huffStreamPkg::codeWord_t    word,
    input  logic                        load,
    input  huffStreamPkg::matchResult_t match,
    output huffStreamPkg::codeWord_t    windowHead,
    output logic                        headValid,
    output logic                        ready
);

    huffStreamPkg::window_t    window;      // Valid bits from MSB down
    huffStreamPkg::window_t    windowNext;
    huffStreamPkg::window_t    placedWord;
    huffStreamPkg::fillCount_t fillCount;
    huffStreamPkg::fillCount_t fillNext;
    huffStreamPkg::fillCount_t consumeLen;
    huffStreamPkg::fillCount_t keptCount;

    //============================================================
    // Next window contents
    //============================================================

    assign consumeLen = match.valid ? huffStreamPkg::fillCount_t'(match.length) : '0;
    assign keptCount  = fillCount - consumeLen;  // Bits left after the shift

    // New word lands right behind the surviving bits
    assign placedWord = {word, {(huffStreamPkg::WindowWidth - huffStreamPkg::WordWidth){1'b0}}}
                        >> keptCount;

    assign windowNext = (window << consumeLen) | (load ? placedWord : '0);
    assign fillNext   = keptCount
                        + (load ? huffStreamPkg::fillCount_t'(huffStreamPkg::WordWidth)
                                : '0);

    // Bits below the fill count stay zero, so the OR above is safe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            window    <= '0;
            fillCount <= '0;
        end else begin
            window    <= windowNext;
            fillCount <= fillNext;
        end
    end

    //============================================================
    // Status toward the source and the matcher
    //============================================================

    assign windowHead = window[huffStreamPkg::WindowWidth-1 -: huffStreamPkg::WordWidth];
    assign headValid  = fillCount >= huffStreamPkg::fillCount_t'(huffStreamPkg::WordWidth);
    assign ready      = fillCount <= huffStreamPkg::fillCount_t'(huffStreamPkg::WordWidth);

    // Source must wait for room
    loadWhileFull: assert property (@(posedge clk) disable iff (!rst) load |-> ready)
        else $error("bitWindow: load while not ready");

    // Window never overflows across load and consume
    fillInRange: assert property (@(posedge clk) disable iff (!rst)
                                  fillCount <= huffStreamPkg::WindowWidth)
        else $error("bitWindow: fill count %0d above capacity", fillCount);

endmodule

//--- logic/prefixMatcher.sv
`timescale 1ns/1ps

module prefixMatcher (
    input  huffStreamPkg::codeWord_t    windowHead,
    input  logic                        headValid,
    output huffStreamPkg::matchResult_t match
);

    huffAlphabetPkg::symbolIndex_t symbol;
    huffStreamPkg::codeLength_t    length;

    //============================================================
    // Whole code tree as one priority decision
    //============================================================

    always_comb begin
        casez (windowHead)
            // 3 bit codes
            10'b010_???????: {symbol, length} = {5'd0, 4'd3};    // S
            10'b001_???????: {symbol, length} = {5'd1, 4'd3};    // K
            10'b000_???????: {symbol, length} = {5'd2, 4'd3};    // R

            // 4 bit codes
            10'b1111_??????: {symbol, length} = {5'd3, 4'd4};    // J
            10'b1110_??????: {symbol, length} = {5'd4, 4'd4};    // T
            10'b1011_??????: {symbol, length} = {5'd5, 4'd4};    // Q
            10'b1010_??????: {symbol, length} = {5'd6, 4'd4};    // I
            10'b1001_??????: {symbol, length} = {5'd7, 4'd4};    // U
            10'b1000_??????: {symbol, length} = {5'd8, 4'd4};    // L

            // 5 bit codes
            10'b11010_?????: {symbol, length} = {5'd9, 4'd5};    // V
            10'b11001_?????: {symbol, length} = {5'd10, 4'd5};   // H
            10'b11000_?????: {symbol, length} = {5'd11, 4'd5};   // P
            10'b01101_?????: {symbol, length} = {5'd12, 4'd5};   // M
            10'b01100_?????: {symbol, length} = {5'd13, 4'd5};   // W

            // 6 bit codes
            10'b011111_????: {symbol, length} = {5'd14, 4'd6};   // G
            10'b011101_????: {symbol, length} = {5'd15, 4'd6};   // X

            // 7 bit codes
            10'b1101111_???: {symbol, length} = {5'd16, 4'd7};   // O
            10'b1101110_???: {symbol, length} = {5'd17, 4'd7};   // F
            10'b1101100_???: {symbol, length} = {5'd18, 4'd7};   // N
            10'b0111100_???: {symbol, length} = {5'd19, 4'd7};   // Y
            10'b0111000_???: {symbol, length} = {5'd20, 4'd7};   // E

            // 8 bit codes
            10'b11011011_??: {symbol, length} = {5'd21, 4'd8};   // Z
            10'b01111011_??: {symbol, length} = {5'd22, 4'd8};   // a
            10'b01111010_??: {symbol, length} = {5'd23, 4'd8};   // D
            10'b01110010_??: {symbol, length} = {5'd24, 4'd8};   // C

            // 9 bit code
            10'b110110101_?: {symbol, length} = {5'd25, 4'd9};   // B

            // 10 bit codes, deepest leaves
            10'b1101101001:  {symbol, length} = {5'd26, 4'd10};  // d
            10'b0111001100:  {symbol, length} = {5'd27, 4'd10};  // e
            10'b0111001101:  {symbol, length} = {5'd28, 4'd10};  // c
            10'b1101101000:  {symbol, length} = {5'd29, 4'd10};  // b
            10'b0111001111:  {symbol, length} = {5'd30, 4'd10};  // f
            10'b0111001110:  {symbol, length} = {5'd31, 4'd10};  // A

            default:         {symbol, length} = {5'd0, 4'd0};    // Not reachable in a full tree
        endcase
    end

    assign match.valid  = headValid;
    assign match.symbol = symbol;
    assign match.length = length;

    // Every 10 bit head hits a leaf, so a valid head always gives a real length
    always_comb begin
        if (headValid) begin
            treeComplete: assert (length >= huffStreamPkg::MinCodeLength
                                  && length <= huffStreamPkg::WordWidth)
                else $error("prefixMatcher: no leaf for head %h", windowHead);
        end
    end

endmodule

//--- logic/symbolMap.sv
`timescale 1ns/1ps

module symbolMap (
    input  logic                           clk,
    input  logic                           rst,
    input  huffStreamPkg::matchResult_t    match,
    output logic                           symbolValid,
    output huffAlphabetPkg::decodedValue_t decodedValue,
    output huffStreamPkg::codeLength_t     symbolLength
);

    huffAlphabetPkg::symbolIndex_t symbolReg;  // Last consumed leaf

    //============================================================
    // Output register
    //============================================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            symbolValid  <= 1'b0;
            symbolReg    <= huffAlphabetPkg::IdleSymbol;  // Value 0 after reset
            symbolLength <= '0;
        end else begin
            symbolValid <= match.valid;  // One pulse per consumed code
            if (match.valid) begin
                symbolReg    <= match.symbol;
                symbolLength <= match.length;
            end
        end
    end

    // Table lookup after the register, lines up with symbolValid
    assign decodedValue = huffAlphabetPkg::DecodeTable[symbolReg];

    // A pulse always carries a length the tree can produce
    lengthOnPulse: assert property (@(posedge clk) disable iff (!rst)
                                    symbolValid |-> symbolLength >= huffStreamPkg::MinCodeLength)
        else $error("symbolMap: pulse with length %0d", symbolLength);

endmodule

//--- logic/huffmanDecoder.sv
`timescale 1ns/1ps

module huffmanDecoder (
    input  logic                           clk,
    input  logic                           rst,
    input  huffStreamPkg::codeWord_t       word,
    input  logic                           load,
    output logic                           ready,
    output logic                           symbolValid,
    output huffAlphabetPkg::decodedValue_t decodedValue,
    output huffStreamPkg::codeLength_t     symbolLength
);

    huffStreamPkg::codeWord_t    windowHead;  // Next 10 stream bits
    logic                        headValid;
    huffStreamPkg::matchResult_t match;       // Feeds both window and output stage

    //============================================================
    // Window, matcher and output stage
    //============================================================

    bitWindow uBitWindow (
        .clk        (clk),
        .rst        (rst),
        .word       (word),
        .load       (load),
        .match      (match),
        .windowHead (windowHead),
        .headValid  (headValid),
        .ready      (ready)
    );

    // Same cycle match, consumed at the next edge
    prefixMatcher uPrefixMatcher (
        .windowHead (windowHead),
        .headValid  (headValid),
        .match      (match)
    );

    symbolMap uSymbolMap (
        .clk          (clk),
        .rst          (rst),
        .match        (match),
        .symbolValid  (symbolValid),
        .decodedValue (decodedValue),
        .symbolLength (symbolLength)
    );

endmodule

//--- include/tbCodeTable.svh
`ifndef TB_CODE_TABLE_SVH
`define TB_CODE_TABLE_SVH

// One row per leaf: code right aligned in bits, code length, decoded value
typedef struct packed {
    huffStreamPkg::codeWord_t       bits;
    huffStreamPkg::codeLength_t     length;
    huffAlphabetPkg::decodedValue_t value;
} codeEntry_t;

// Leaf order S K R J T Q I U L V H P M W G X O F N Y E Z a D C B d e c b f A
localparam codeEntry_t CodeTable [32] = '{
    '{10'b0000000010, 4'd3,  5'd18},  // S
    '{10'b0000000001, 4'd3,  5'd10},  // K
    '{10'b0000000000, 4'd3,  5'd17},  // R
    '{10'b0000001111, 4'd4,  5'd9},   // J
    '{10'b0000001110, 4'd4,  5'd19},  // T
    '{10'b0000001011, 4'd4,  5'd16},  // Q
    '{10'b0000001010, 4'd4,  5'd8},   // I
    '{10'b0000001001, 4'd4,  5'd20},  // U
    '{10'b0000001000, 4'd4,  5'd11},  // L
    '{10'b0000011010, 4'd5,  5'd21},  // V
    '{10'b0000011001, 4'd5,  5'd7},   // H
    '{10'b0000011000, 4'd5,  5'd15},  // P
    '{10'b0000001101, 4'd5,  5'd12},  // M
    '{10'b0000001100, 4'd5,  5'd22},  // W
    '{10'b0000011111, 4'd6,  5'd6},   // G
    '{10'b0000011101, 4'd6,  5'd23},  // X
    '{10'b0001101111, 4'd7,  5'd14},  // O
    '{10'b0001101110, 4'd7,  5'd5},   // F
    '{10'b0001101100, 4'd7,  5'd13},  // N
    '{10'b0000111100, 4'd7,  5'd24},  // Y
    '{10'b0000111000, 4'd7,  5'd4},   // E
    '{10'b0011011011, 4'd8,  5'd25},  // Z
    '{10'b0001111011, 4'd8,  5'd26},  // a
    '{10'b0001111010, 4'd8,  5'd3},   // D
    '{10'b0001110010, 4'd8,  5'd2},   // C
    '{10'b0110110101, 4'd9,  5'd1},   // B
    '{10'b1101101001, 4'd10, 5'd29},  // d
    '{10'b0111001100, 4'd10, 5'd30},  // e
    '{10'b0111001101, 4'd10, 5'd28},  // c
    '{10'b1101101000, 4'd10, 5'd27},  // b
    '{10'b0111001111, 4'd10, 5'd31},  // f
    '{10'b0111001110, 4'd10, 5'd0}    // A
};

`endif

//--- sim/huffmanDecoderTb.sv
`timescale 1ns/1ps

module huffmanDecoderTb;

    `include "tbCodeTable.svh"

    localparam int ClockHalf      = 50;   // 100 ns period
    localparam int ResetCycles    = 10;
    localparam int DirectSymbols  = 32;
    localparam int RandomSymbols  = 300;
    localparam int DrainCycles    = 12;
    localparam int WatchdogCycles = 200 + 12 * (DirectSymbols + RandomSymbols);

    logic                           clk = 1'b0;
    logic                           rst;
    huffStreamPkg::codeWord_t       word;
    logic                           load;
    logic                           ready;
    logic                           symbolValid;
    huffAlphabetPkg::decodedValue_t decodedValue;
    huffStreamPkg::codeLength_t     symbolLength;

    integer     seed;
    bit         bitQueue [$];     // Encoded stream, oldest bit first
    codeEntry_t expectQ [$];      // Codes not yet consumed by the model
    int         sentLength [$];
    codeEntry_t expEntry;         // Code the model consumed last
    logic       expValid;
    logic       anyLoad;
    int         mirrorFill;
    int         loadedBits;
    int         pulseCount;

    huffmanDecoder u_dut (
        .clk          (clk),
        .rst          (rst),
        .word         (word),
        .load         (load),
        .ready        (ready),
        .symbolValid  (symbolValid),
        .decodedValue (decodedValue),
        .symbolLength (symbolLength)
    );

    always #(ClockHalf) clk = ~clk;

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1);
    endtask

    //============================================================
    // Stream encoding and the cycle model
    //============================================================

    task automatic encodeSymbol(input int idx);
        codeEntry_t entry;
        int         b;
        entry = CodeTable[idx];
        for (b = int'(entry.length) - 1; b >= 0; b--) begin
            bitQueue.push_back(entry.bits[b]);
        end
        expectQ.push_back(entry);
        sentLength.push_back(int'(entry.length));
    endtask

    // Model the edge just taken, then drive the next cycle
    task automatic stepCycle(input bit allowPause);
        bit wantLoad;
        int i;
        @(posedge clk);
        #1;
        expValid = 1'b0;
        if (mirrorFill >= huffStreamPkg::WordWidth && expectQ.size() > 0) begin
            expEntry   = expectQ.pop_front();
            mirrorFill = mirrorFill - int'(expEntry.length);
            expValid   = 1'b1;
        end
        if (load) begin
            mirrorFill = mirrorFill + huffStreamPkg::WordWidth;  // Lands behind kept bits
        end
        wantLoad = ready && bitQueue.size() >= huffStreamPkg::WordWidth;
        if (allowPause && ($random(seed) % 4 == 0)) begin
            wantLoad = 1'b0;  // Source pause
        end
        if (wantLoad) begin
            for (i = 0; i < huffStreamPkg::WordWidth; i++) begin
                word[huffStreamPkg::WordWidth-1-i] = bitQueue.pop_front();
            end
            load       = 1'b1;
            anyLoad    = 1'b1;
            loadedBits = loadedBits + huffStreamPkg::WordWidth;
        end else begin
            load = 1'b0;
        end
    endtask

    task automatic runStream(input bit allowPause);
        while (bitQueue.size() >= huffStreamPkg::WordWidth) begin
            stepCycle(allowPause);
        end
        repeat (DrainCycles) stepCycle(1'b0);  // Window runs dry, tail stays
    endtask

    // A code is consumed once 10 bits from its start have been loaded
    function automatic int countConsumable(input int loaded);
        int start;
        int count;
        start = 0;
        count = 0;
        foreach (sentLength[i]) begin
            if (start + huffStreamPkg::WordWidth <= loaded) begin
                count++;
            end
            start = start + sentLength[i];
        end
        return count;
    endfunction

    always @(posedge clk) begin
        if (rst && symbolValid) begin
            pulseCount <= pulseCount + 1;
        end
    end

    //============================================================
    // Checks
    //============================================================

    idleReady: assert property (@(posedge clk) disable iff (!rst) !anyLoad |-> ready)
        else stopOnError($sformatf("** Error ready: expected %h, actual %h", 1'b1,
                                   $sampled(ready)));

    readyRule: assert property (@(posedge clk) disable iff (!rst)
                                ready == (mirrorFill <= huffStreamPkg::WordWidth))
        else stopOnError($sformatf("** Error ready: expected %h, actual %h",
                                   $sampled(mirrorFill <= huffStreamPkg::WordWidth),
                                   $sampled(ready)));

    // Also covers the quiet start and the stop after a pause
    validRule: assert property (@(posedge clk) disable iff (!rst) symbolValid == expValid)
        else stopOnError($sformatf("** Error symbolValid: expected %h, actual %h",
                                   $sampled(expValid), $sampled(symbolValid)));

    valueRule: assert property (@(posedge clk) disable iff (!rst)
                                symbolValid |-> decodedValue == expEntry.value)
        else stopOnError($sformatf("** Error decodedValue: expected %h, actual %h",
                                   $sampled(expEntry.value), $sampled(decodedValue)));

    lengthRule: assert property (@(posedge clk) disable iff (!rst)
                                 symbolValid |-> symbolLength == expEntry.length)
        else stopOnError($sformatf("** Error symbolLength: expected %h, actual %h",
                                   $sampled(expEntry.length), $sampled(symbolLength)));

    //============================================================
    // Main sequence and watchdog
    //============================================================

    initial begin
        int i;
        int expectedPulses;
        seed       = 32'hd455a377;
        rst        = 1'b0;
        word       = '0;
        load       = 1'b0;
        expValid   = 1'b0;
        expEntry   = '0;
        anyLoad    = 1'b0;
        mirrorFill = 0;
        loadedBits = 0;
        pulseCount = 0;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (4) stepCycle(1'b0);  // Idle before first load
        for (i = 0; i < DirectSymbols; i++) begin
            encodeSymbol(i);
        end
        runStream(1'b0);
        for (i = 0; i < RandomSymbols; i++) begin
            encodeSymbol(int'($unsigned($random(seed)) % DirectSymbols));
        end
        runStream(1'b1);
        expectedPulses = countConsumable(loadedBits);
        if (pulseCount != expectedPulses) begin
            stopOnError($sformatf("** Error symbolValid pulses: expected %h, actual %h",
                                  expectedPulses, pulseCount));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        stopOnError("Timeout: the decode run did not finish within the cycle budget");
    end

endmodule

//--- build.f
+incdir+include
logic/huffAlphabetPkg.sv
logic/huffStreamPkg.sv
logic/bitWindow.sv
logic/prefixMatcher.sv
logic/symbolMap.sv
logic/huffmanDecoder.sv
sim/huffmanDecoderTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := huffmanDecoderTb
RTL_TOP   := huffmanDecoder
FILELIST  := build.f
OBJDIR    := obj_dir
SIMFLAGS  := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing --assert -Wall -Wno-fatal

.PHONY: all lint sim clean

all: sim

# Lint the RTL hierarchy
lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build and run, a $$fatal gives a nonzero exit status
sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
